// File: flist.f
isa_pkg.sv
core_pkg.sv
control.sv
fetch_unit.sv
reg_file.sv
execute_unit.sv
data_mem.sv
mips_core.sv
mips_core_asserts.sv
tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - isa_pkg.sv
  - core_pkg.sv
  - control.sv
  - fetch_unit.sv
  - reg_file.sv
  - execute_unit.sv
  - data_mem.sv
  - mips_core.sv
  - target: test
    files:
      - mips_core_asserts.sv
      - tb_mips_core.sv

// File: tb_mips_core.sv
`default_nettype none

module tb_mips_core;

	timeunit 1ns;
	timeprecision 1ps;

	import isa_pkg::*;
	import core_pkg::*;

	localparam int TIMEOUT_CYCLES = 20;

	typedef struct packed {
		word_t instr;
		word_t pc;
		logic rf_we;
		logic [REG_ADDR_W-1:0] rf_addr;
		word_t rf_data;
		logic dm_we;
		logic dm_chk;
		word_t dm_addr;
	} entry_t;

	logic clk;
	logic rst;
	prog_wr_t prog;
	commit_t commit;
	entry_t table_q[$];
	int errors;
	int checks;

	mips_core mips_core_i (
		.clk(clk),
		.rst(rst),
		.prog(prog),
		.commit(commit)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic word_t enc_r(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] funct);
		return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic add_entry(input word_t instr, input word_t pc, input logic rf_we,
			input logic [4:0] rf_addr, input word_t rf_data, input logic dm_we,
			input logic dm_chk, input word_t dm_addr);
		entry_t e;
		e = '{instr, pc, rf_we, rf_addr, rf_data, dm_we, dm_chk, dm_addr};
		table_q.push_back(e);
	endtask

	task automatic build_table();
		add_entry(enc_i(OP_LUI, 5'd0, 5'd1, 16'h1234), 32'd0, 1, 5'd1, 32'h1234_0000, 0, 0, 0);
		add_entry(enc_i(OP_ORI, 5'd1, 5'd1, 16'h8765), 32'd4, 1, 5'd1, 32'h1234_8765, 0, 0, 0);
		add_entry(enc_i(OP_ORI, 5'd0, 5'd2, 16'h0005), 32'd8, 1, 5'd2, 32'd5, 0, 0, 0);
		add_entry(enc_i(OP_ORI, 5'd0, 5'd3, 16'h0007), 32'd12, 1, 5'd3, 32'd7, 0, 0, 0);
		add_entry(enc_r(5'd2, 5'd3, 5'd4, FUNCT_SUBU), 32'd16, 1, 5'd4, 32'hffff_fffe, 0, 0, 0);
		add_entry(enc_r(5'd4, 5'd3, 5'd5, FUNCT_ADDU), 32'd20, 1, 5'd5, 32'd5, 0, 0, 0);
		add_entry(enc_i(OP_ORI, 5'd0, 5'd6, 16'h0040), 32'd24, 1, 5'd6, 32'h40, 0, 0, 0);
		add_entry(enc_i(OP_ORI, 5'd0, 5'd8, 16'h004c), 32'd28, 1, 5'd8, 32'h4c, 0, 0, 0);
		add_entry(enc_i(OP_SW, 5'd6, 5'd1, 16'h0008), 32'd32, 0, 5'd0, 32'd0, 1, 1, 32'h48);
		add_entry(enc_i(OP_LW, 5'd8, 5'd7, 16'hfffc), 32'd36, 1, 5'd7, 32'h1234_8765, 0, 1, 32'h48);
		add_entry(enc_i(OP_BEQ, 5'd2, 5'd3, 16'h0002), 32'd40, 0, 5'd0, 32'd0, 0, 0, 0);
		add_entry(enc_i(OP_BEQ, 5'd5, 5'd2, 16'h0001), 32'd44, 0, 5'd0, 32'd0, 0, 0, 0);
		add_entry(enc_r(5'd2, 5'd3, 5'd0, FUNCT_ADDU), 32'd52, 1, 5'd0, 32'd12, 0, 0, 0);
		add_entry(enc_r(5'd0, 5'd2, 5'd10, FUNCT_ADDU), 32'd56, 1, 5'd10, 32'd5, 0, 0, 0);
		add_entry(32'h0000_0000, 32'd60, 0, 5'd0, 32'd0, 0, 0, 0);
		add_entry(32'hfc21_0001, 32'd64, 0, 5'd0, 32'd0, 0, 0, 0); // opcode 0x3f is not decoded.
		add_entry(enc_i(OP_ORI, 5'd0, 5'd11, 16'h0001), 32'd68, 1, 5'd11, 32'd1, 0, 0, 0);
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic load_word(input logic [MEM_ADDR_W-1:0] addr, input word_t data);
		@(posedge clk);
		#1;
		prog = '{valid: 1'b1, addr: addr, data: data};
		#4;
		check_value("commit.valid", 32'd0, word_t'(commit.valid));
	endtask

	task automatic wait_commit(output logic timed_out);
		int cycles;
		cycles = 0;
		while (commit.valid !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#5;
			cycles++;
		end
		timed_out = (commit.valid !== 1'b1);
		if (timed_out) begin
			errors++;
			$display("timed out at %0d ns waiting for the core to commit", $time);
		end
	endtask

	initial begin
		entry_t e;
		logic timed_out;
		rst = 1'b1;
		prog = '0;
		errors = 0;
		checks = 0;
		build_table();
		foreach (table_q[i]) begin
			load_word(table_q[i].pc[MEM_ADDR_W+1:2], table_q[i].instr);
		end
		load_word(8'd12, enc_i(OP_ORI, 5'd0, 5'd9, 16'hdead)); // skipped by the taken beq.
		load_word(8'd18, 32'h0000_0000);
		repeat (5) begin
			@(posedge clk);
			#1;
			prog = '0;
			#4;
			check_value("commit.valid", 32'd0, word_t'(commit.valid));
		end
		@(posedge clk);
		#1;
		rst = 1'b0;
		#4;
		foreach (table_q[i]) begin
			wait_commit(timed_out);
			if (timed_out) begin
				break;
			end
			e = table_q[i];
			check_value("commit.pc", e.pc, commit.pc);
			check_value("commit.instr", e.instr, commit.instr);
			check_value("commit.rf_we", word_t'(e.rf_we), word_t'(commit.rf_we));
			check_value("commit.dm_we", word_t'(e.dm_we), word_t'(commit.dm_we));
			if (e.rf_we) begin
				check_value("commit.rf_addr", word_t'(e.rf_addr), word_t'(commit.rf_addr));
				check_value("commit.rf_data", e.rf_data, commit.rf_data);
			end
			if (e.dm_chk) begin
				check_value("commit.dm_addr", e.dm_addr, commit.dm_addr);
			end
			@(posedge clk);
			#5;
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mips_core_asserts.sv
`default_nettype none

module mips_core_asserts (
	input logic clk,
	input logic rst,
	input core_pkg::commit_t commit,
	input isa_pkg::word_t pc,
	input isa_pkg::instr_kind_t kind,
	input logic branch_eq,
	input logic eq
);

	timeunit 1ns;
	timeprecision 1ps;

	import isa_pkg::*;

	no_commit_in_reset: assert property (@(posedge clk)
			rst |-> !commit.valid ##1 commit.pc == '0)
		else $error("commit is active or the pc is not cleared during reset");

	pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned", pc);

	single_write: assert property (@(posedge clk) !(commit.rf_we && commit.dm_we))
		else $error("register and memory writes in the same cycle");

	inert_kind: assert property (@(posedge clk)
			(kind == KIND_NOP || kind == KIND_UNKNOWN) |-> !commit.rf_we && !commit.dm_we)
		else $error("a nop or unknown instruction writes state");

	// a fall-through instruction moves the pc by one word.
	pc_step: assert property (@(posedge clk) disable iff (rst)
			!(branch_eq && eq) |=> pc == $past(pc) + 32'd4)
		else $error("pc %h does not follow %h", pc, $past(pc));

endmodule

bind mips_core mips_core_asserts mips_core_asserts_i (
	.clk(clk),
	.rst(rst),
	.commit(commit),
	.pc(pc),
	.kind(kind),
	.branch_eq(ctrl.branch_eq),
	.eq(eq)
);

`default_nettype wire

// File: mips_core.sv
`default_nettype none

module mips_core (
	input logic clk,
	input logic rst,
	input core_pkg::prog_wr_t prog,
	output core_pkg::commit_t commit
);

	import isa_pkg::*;
	import core_pkg::*;

	word_t pc;
	word_t instr;
	instr_kind_t kind;
	ctrl_word_t ctrl;
	word_t rs_data;
	word_t rt_data;
	word_t alu_result;
	word_t dm_rd_data;
	word_t wb_data;
	logic eq;
	logic rf_we;
	logic dm_we;
	logic [REG_ADDR_W-1:0] wr_addr;

	fetch_unit fetch_unit_i (
		.clk(clk),
		.rst(rst),
		.prog(prog),
		.branch_eq(ctrl.branch_eq),
		.eq(eq),
		.pc(pc),
		.instr(instr)
	);

	control control_i (
		.instr(instr),
		.kind(kind),
		.ctrl(ctrl)
	);

	assign wr_addr = (ctrl.wb_addr_sel == WB_ADDR_RD) ?
		instr[RD_MSB:RD_LSB] : instr[RT_MSB:RT_LSB];
	assign wb_data = (ctrl.wb_data_sel == WB_DATA_MEM) ? dm_rd_data : alu_result;
	assign rf_we = ctrl.rf_we && !rst; // nothing is written while the program loads.
	assign dm_we = ctrl.dm_we && !rst;

	reg_file reg_file_i (
		.clk(clk),
		.rs_addr(instr[RS_MSB:RS_LSB]),
		.rt_addr(instr[RT_MSB:RT_LSB]),
		.wr_addr(wr_addr),
		.we(rf_we),
		.wr_data(wb_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	execute_unit execute_unit_i (
		.imm(instr[IMM_MSB:IMM_LSB]),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.ctrl(ctrl),
		.alu_result(alu_result),
		.eq(eq)
	);

	data_mem data_mem_i (
		.clk(clk),
		.addr(alu_result),
		.we(dm_we),
		.wr_data(rt_data), // sw stores rt.
		.rd_data(dm_rd_data)
	);

	always_comb begin
		commit.valid = !rst;
		commit.pc = pc;
		commit.instr = instr;
		commit.rf_we = rf_we;
		commit.rf_addr = wr_addr;
		commit.rf_data = wb_data;
		commit.dm_we = dm_we;
		commit.dm_addr = alu_result;
	end

endmodule

`default_nettype wire

// File: data_mem.sv
`default_nettype none

module data_mem (
	input logic clk,
	input isa_pkg::word_t addr,
	input logic we,
	input isa_pkg::word_t wr_data,
	output isa_pkg::word_t rd_data
);

	import isa_pkg::*;
	import core_pkg::*;

	word_t mem [DM_DEPTH];
	logic [MEM_ADDR_W-1:0] word_addr;

	assign word_addr = addr[MEM_ADDR_W+1:2]; // the byte offset is dropped.

	always_ff @(posedge clk) begin
		if (we) begin
			mem[word_addr] <= wr_data;
		end
	end

	assign rd_data = mem[word_addr];

endmodule

`default_nettype wire

// File: execute_unit.sv
`default_nettype none

module execute_unit (
	input logic [isa_pkg::IMM_W-1:0] imm,
	input isa_pkg::word_t rs_data,
	input isa_pkg::word_t rt_data,
	input core_pkg::ctrl_word_t ctrl,
	output isa_pkg::word_t alu_result,
	output logic eq
);

	import isa_pkg::*;
	import core_pkg::*;

	word_t imm_ext;
	word_t operand_b;

	always_comb begin
		case (ctrl.ext_mode)
			EXT_ZERO: imm_ext = {{(WORD_W-IMM_W){1'b0}}, imm};
			EXT_SIGN: imm_ext = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
			EXT_PAD: imm_ext = {imm, {(WORD_W-IMM_W){1'b0}}};
			default: imm_ext = '0;
		endcase
	end

	assign operand_b = (ctrl.alu_src_sel == ALU_SRC_IMM) ? imm_ext : rt_data;

	// sums wrap around, as addu and subu never trap.
	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD: alu_result = rs_data + operand_b;
			ALU_SUB: alu_result = rs_data - operand_b;
			ALU_OR: alu_result = rs_data | operand_b;
			default: alu_result = '0;
		endcase
	end

	assign eq = (rs_data == rt_data);

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file (
	input logic clk,
	input logic [isa_pkg::REG_ADDR_W-1:0] rs_addr,
	input logic [isa_pkg::REG_ADDR_W-1:0] rt_addr,
	input logic [isa_pkg::REG_ADDR_W-1:0] wr_addr,
	input logic we,
	input isa_pkg::word_t wr_data,
	output isa_pkg::word_t rs_data,
	output isa_pkg::word_t rt_data
);

	import isa_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr]; // register zero is never stored.
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: fetch_unit.sv
`default_nettype none

module fetch_unit (
	input logic clk,
	input logic rst,
	input core_pkg::prog_wr_t prog,
	input logic branch_eq,
	input logic eq,
	output isa_pkg::word_t pc,
	output isa_pkg::word_t instr
);

	import isa_pkg::*;
	import core_pkg::*;

	word_t imem [IM_DEPTH];
	word_t pc_plus4;
	word_t branch_off;
	word_t pc_next;
	logic [IMM_W-1:0] imm;

	assign imm = instr[IMM_MSB:IMM_LSB];
	assign pc_plus4 = pc + 32'd4;
	assign branch_off = {{(WORD_W-IMM_W-2){imm[IMM_W-1]}}, imm, 2'b00};
	assign pc_next = (branch_eq && eq) ? pc_plus4 + branch_off : pc_plus4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// the program only loads while the core is held in reset.
	always_ff @(posedge clk) begin
		if (rst && prog.valid) begin
			imem[prog.addr] <= prog.data;
		end
	end

	assign instr = imem[pc[MEM_ADDR_W+1:2]];

endmodule

`default_nettype wire

// File: control.sv
`default_nettype none

module control (
	input isa_pkg::word_t instr,
	output isa_pkg::instr_kind_t kind,
	output core_pkg::ctrl_word_t ctrl
);

	import isa_pkg::*;
	import core_pkg::*;

	logic [OP_W-1:0] opcode;
	logic [FUNCT_W-1:0] funct;

	assign opcode = instr[OP_MSB:OP_LSB];
	assign funct = instr[FUNCT_MSB:FUNCT_LSB];

	always_comb begin
		if (instr == '0) begin
			kind = KIND_NOP; // checked first since it shares the r-type opcode.
		end else begin
			case (opcode)
				OP_RTYPE: begin
					if (funct == FUNCT_ADDU) begin
						kind = KIND_ADDU;
					end else if (funct == FUNCT_SUBU) begin
						kind = KIND_SUBU;
					end else begin
						kind = KIND_UNKNOWN;
					end
				end
				OP_LUI: kind = KIND_LUI;
				OP_ORI: kind = KIND_ORI;
				OP_LW: kind = KIND_LW;
				OP_SW: kind = KIND_SW;
				OP_BEQ: kind = KIND_BEQ;
				default: kind = KIND_UNKNOWN;
			endcase
		end
	end

	always_comb begin
		ctrl = CTRL_IDLE;
		case (kind)
			KIND_ADDU, KIND_SUBU: begin
				ctrl.wb_addr_sel = WB_ADDR_RD;
				ctrl.alu_op = (kind == KIND_ADDU) ? ALU_ADD : ALU_SUB;
				ctrl.rf_we = 1'b1;
			end
			KIND_LUI, KIND_ORI: begin
				ctrl.alu_src_sel = ALU_SRC_IMM;
				ctrl.ext_mode = (kind == KIND_LUI) ? EXT_PAD : EXT_ZERO; // lui ors the pad into zero.
				ctrl.rf_we = 1'b1;
			end
			KIND_LW: begin
				ctrl.wb_data_sel = WB_DATA_MEM;
				ctrl.alu_src_sel = ALU_SRC_IMM;
				ctrl.alu_op = ALU_ADD;
				ctrl.ext_mode = EXT_SIGN;
				ctrl.rf_we = 1'b1;
			end
			KIND_SW: begin
				ctrl.alu_src_sel = ALU_SRC_IMM;
				ctrl.alu_op = ALU_ADD;
				ctrl.ext_mode = EXT_SIGN;
				ctrl.dm_we = 1'b1;
			end
			KIND_BEQ: begin
				ctrl.alu_op = ALU_SUB;
				ctrl.branch_eq = 1'b1;
			end
			default: ctrl = CTRL_IDLE;
		endcase
	end

endmodule

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int IM_DEPTH = 256;
	localparam int DM_DEPTH = 256;
	localparam int MEM_ADDR_W = 8; // both memories are word addressed.

	typedef enum logic {WB_ADDR_RD, WB_ADDR_RT} wb_addr_sel_t;
	typedef enum logic {WB_DATA_ALU, WB_DATA_MEM} wb_data_sel_t;
	typedef enum logic {ALU_SRC_RT, ALU_SRC_IMM} alu_src_sel_t;
	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_OR} alu_op_t;
	typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_PAD} ext_mode_t;

	typedef struct packed {
		wb_addr_sel_t wb_addr_sel;
		wb_data_sel_t wb_data_sel;
		alu_src_sel_t alu_src_sel;
		alu_op_t alu_op;
		ext_mode_t ext_mode;
		logic rf_we;
		logic dm_we;
		logic branch_eq;
	} ctrl_word_t;

	// control word of an instruction that changes nothing but the pc.
	localparam ctrl_word_t CTRL_IDLE = '{
		wb_addr_sel: WB_ADDR_RT,
		wb_data_sel: WB_DATA_ALU,
		alu_src_sel: ALU_SRC_RT,
		alu_op: ALU_OR,
		ext_mode: EXT_ZERO,
		rf_we: 1'b0,
		dm_we: 1'b0,
		branch_eq: 1'b0
	};

	typedef struct packed {
		logic valid;
		logic [MEM_ADDR_W-1:0] addr;
		isa_pkg::word_t data;
	} prog_wr_t;

	typedef struct packed {
		logic valid;
		isa_pkg::word_t pc;
		isa_pkg::word_t instr;
		logic rf_we;
		logic [isa_pkg::REG_ADDR_W-1:0] rf_addr;
		isa_pkg::word_t rf_data;
		logic dm_we;
		isa_pkg::word_t dm_addr;
	} commit_t;

endpackage

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int WORD_W = 32;
	localparam int NUM_REGS = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OP_W = 6;
	localparam int FUNCT_W = 6;
	localparam int IMM_W = 16;

	// bit positions of the instruction fields.
	localparam int OP_MSB = 31;
	localparam int OP_LSB = 26;
	localparam int RS_MSB = 25;
	localparam int RS_LSB = 21;
	localparam int RT_MSB = 20;
	localparam int RT_LSB = 16;
	localparam int RD_MSB = 15;
	localparam int RD_LSB = 11;
	localparam int FUNCT_MSB = 5;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_MSB = 15;
	localparam int IMM_LSB = 0;

	localparam logic [OP_W-1:0] OP_RTYPE = 6'h00;
	localparam logic [OP_W-1:0] OP_LUI = 6'h0f;
	localparam logic [OP_W-1:0] OP_ORI = 6'h0d;
	localparam logic [OP_W-1:0] OP_LW = 6'h23;
	localparam logic [OP_W-1:0] OP_SW = 6'h2b;
	localparam logic [OP_W-1:0] OP_BEQ = 6'h04;
	localparam logic [FUNCT_W-1:0] FUNCT_ADDU = 6'h21;
	localparam logic [FUNCT_W-1:0] FUNCT_SUBU = 6'h23;

	typedef logic [WORD_W-1:0] word_t;

	typedef enum logic [3:0] {
		KIND_ADDU,
		KIND_SUBU,
		KIND_LUI,
		KIND_ORI,
		KIND_LW,
		KIND_SW,
		KIND_BEQ,
		KIND_NOP,
		KIND_UNKNOWN
	} instr_kind_t;

endpackage

`default_nettype wire
